/* files.f */
rtl/floor_pkg.sv
rtl/dispatch_if.sv
rtl/request_register.sv
rtl/destination_dispatcher.sv
rtl/floor_request_top.sv
dv/car_model.sv
dv/floor_request_tb.sv

/* Makefile */
# Verilator build and run for the floor request testbench

VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert
TOP         = floor_request_tb
FILELIST    = files.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_TEXT   = Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/floor_request_tb.sv */
/*
 * Floor request testbench
 * Random button, emergency and power stimulus against a cycle model of
 * the request lights and the dispatcher, with a behavioral car
 */

`default_nettype none

module floor_request_tb;
    import floor_pkg::*;

    localparam int PERIOD        = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int TRAVEL_CYCLES = 6;
    localparam int NUM_CYCLES    = 4000;
    localparam int DRAIN_CYCLES  = 400;
    localparam int TIMEOUT       = (RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES) * PERIOD + 200;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      floor_selector;
    logic        direction_selector;
    logic        activate_elevator;

    // Reference state as the DUT shows it after the coming edge
    floor_mask_t     model_call;
    floor_mask_t     model_panel;
    dispatch_state_t model_state;
    floor_t          model_selector;
    logic            model_direction;
    logic            model_serviced;
    floor_t          model_serviced_floor;

    integer seed;
    int     emergency_left;
    int     power_off_left;
    int     targets_chosen;
    int     floors_serviced;
    int     wait_cycles;

    floor_request_top dut (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .floor_selector      (floor_selector),
        .direction_selector  (direction_selector),
        .activate_elevator   (activate_elevator)
    );

    car_model #(.TRAVEL_CYCLES(TRAVEL_CYCLES)) car (
        .clock              (clock),
        .reset_n            (reset_n),
        .activate_elevator  (activate_elevator),
        .direction_selector (direction_selector),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving)
    );

    always #(PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_mask(floor_mask_t actual, floor_mask_t expected, string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_floor(floor_t actual, floor_t expected, string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_bit(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic floor_mask_t floor_bit(floor_t floor);
        return floor_mask_t'(1) << floor;
    endfunction

    // Search from the top landing down
    function automatic floor_t highest_pending(floor_mask_t mask);
        floor_t top;
        logic   found;
        top   = '0;
        found = 1'b0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (!found && mask[i]) begin
                top   = floor_t'(i);
                found = 1'b1;
            end
        end
        return top;
    endfunction

    // Never high while the car is moving
    function automatic logic expected_activate();
        return (model_state == DISP_ACTIVE) && power_switch && !emergency_btn
               && !elevator_moving && (current_floor != model_selector);
    endfunction

    task automatic step_model();
        logic        enable;
        logic        ready;
        floor_mask_t pending;
        floor_mask_t here;
        floor_mask_t cleared;
        enable  = power_switch && !emergency_btn;
        ready   = enable && !elevator_moving && !model_serviced;
        pending = model_call | model_panel;
        here    = floor_bit(current_floor);
        cleared = model_serviced ? floor_bit(model_serviced_floor) : '0;
        if (enable) begin
            model_call  = (model_call | (floor_call_buttons & ~here)) & ~cleared;
            model_panel = (model_panel | (panel_buttons & ~here)) & ~cleared;
        end
        model_serviced = 1'b0;
        // Dispatcher waits one cycle after a strobe for pending to drop
        if (ready) begin
            if (model_state == DISP_IDLE) begin
                if ((pending & here) != '0) begin
                    model_serviced       = 1'b1;
                    model_serviced_floor = current_floor;
                    floors_serviced++;
                end else if (pending != '0) begin
                    model_selector  = highest_pending(pending);
                    model_direction = (model_selector > current_floor) ? DIR_UP : DIR_DOWN;
                    model_state     = DISP_ACTIVE;
                    targets_chosen++;
                end
            end else if (current_floor == model_selector) begin
                model_serviced       = 1'b1;
                model_serviced_floor = model_selector;
                model_state          = DISP_IDLE;
                floors_serviced++;
            end
        end
    endtask

    task automatic compare_outputs();
        check_mask(call_button_lights, model_call, "call_button_lights");
        check_mask(panel_button_lights, model_panel, "panel_button_lights");
        check_floor(floor_selector, model_selector, "floor_selector");
        check_bit(direction_selector, model_direction, "direction_selector");
        check_bit(activate_elevator, expected_activate(), "activate_elevator");
    endtask

    task automatic check_reset_values();
        check_mask(call_button_lights, '0, "call_button_lights in reset");
        check_mask(panel_button_lights, '0, "panel_button_lights in reset");
        check_floor(floor_selector, '0, "floor_selector in reset");
        check_bit(direction_selector, DIR_UP, "direction_selector in reset");
        check_bit(activate_elevator, 1'b0, "activate_elevator in reset");
    endtask

    // Compare and step the model at the falling edge
    always @(negedge clock) begin
        if (reset_n) begin
            compare_outputs();
            step_model();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_random();
        integer      pick;
        floor_t      floor;
        floor_mask_t calls;
        floor_mask_t panels;
        calls  = '0;
        panels = '0;
        pick   = $random(seed);
        if (pick[3:0] == 4'd0) begin
            floor = floor_t'($unsigned($random(seed)) % NUM_FLOORS);
            calls = floor_bit(floor);
        end
        if (pick[7:4] == 4'd0) begin
            floor  = floor_t'($unsigned($random(seed)) % NUM_FLOORS);
            panels = floor_bit(floor);
        end
        // Rare short emergency and power-off pulses
        if (emergency_left > 0) begin
            emergency_left--;
        end else if (pick[15:8] == 8'd0) begin
            emergency_left = 2 + int'(pick[18:16]);
        end
        if (power_off_left > 0) begin
            power_off_left--;
        end else if (pick[27:20] == 8'd0) begin
            power_off_left = 2 + int'(pick[30:28]);
        end
        floor_call_buttons = calls;
        panel_buttons      = panels;
        emergency_btn      = (emergency_left > 0);
        power_switch       = (power_off_left == 0);
    endtask

    initial begin
        clock                = 1'b0;
        reset_n              = 1'b0;
        floor_call_buttons   = '0;
        panel_buttons        = '0;
        emergency_btn        = 1'b0;
        power_switch         = 1'b1;
        seed                 = 32'h48ae_5a0e;
        emergency_left       = 0;
        power_off_left       = 0;
        targets_chosen       = 0;
        floors_serviced      = 0;
        model_call           = '0;
        model_panel          = '0;
        model_state          = DISP_IDLE;
        model_selector       = '0;
        model_direction      = DIR_UP;
        model_serviced       = 1'b0;
        model_serviced_floor = '0;

        repeat (RESET_CYCLES - 1) @(posedge clock);
        @(negedge clock);
        check_reset_values();
        @(posedge clock);
        #1 reset_n = 1'b1;

        repeat (NUM_CYCLES) begin
            @(posedge clock);
            #1 drive_random();
        end

        // Quiet inputs and let the car work off every request
        @(posedge clock);
        #1;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        wait_cycles        = 0;
        while (((call_button_lights | panel_button_lights) != '0 || model_state != DISP_IDLE)
               && wait_cycles < DRAIN_CYCLES) begin
            @(posedge clock);
            #1;
            wait_cycles++;
        end

        if (wait_cycles < DRAIN_CYCLES && floors_serviced > 0) begin
            $display("%0d targets chosen, %0d floors serviced", targets_chosen, floors_serviced);
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Requests were still lit after the drain phase or none were serviced");
            $display("Testbench failed");
            $fatal(1, "requests not cleared");
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired at %0t before the run finished", $time);
        $display("Testbench failed");
        $fatal(1, "watchdog timeout");
    end

endmodule : floor_request_tb

`default_nettype wire

/* dv/car_model.sv */
/*
 * Behavioral car
 * Moves one landing per fixed travel time in the commanded direction
 * when activation is seen, then stops at that landing
 */

`default_nettype none

module car_model #(
    parameter int TRAVEL_CYCLES = 6
) (
    input  wire logic         clock,
    input  wire logic         reset_n,
    input  wire logic         activate_elevator,
    input  wire logic         direction_selector,
    output floor_pkg::floor_t current_floor,
    output logic              elevator_moving
);
    import floor_pkg::*;

    int   remaining;
    logic going_up;
    logic start;
    logic up_request;
    logic in_reset;

    initial begin
        current_floor   = '0;
        elevator_moving = 1'b0;
        remaining       = 0;
        going_up        = DIR_UP;
        forever begin
            // Commands are taken at the edge, the car answers just after it
            @(posedge clock);
            start      = activate_elevator;
            up_request = direction_selector;
            in_reset   = !reset_n;
            #1;
            if (in_reset) begin
                current_floor   = '0;
                elevator_moving = 1'b0;
                remaining       = 0;
            end else if (elevator_moving) begin
                remaining--;
                if (remaining == 0) begin
                    elevator_moving = 1'b0;
                    if (going_up == DIR_UP && current_floor < floor_t'(NUM_FLOORS - 1)) begin
                        current_floor = current_floor + floor_t'(1);
                    end else if (going_up == DIR_DOWN && current_floor != '0) begin
                        current_floor = current_floor - floor_t'(1);
                    end
                end
            end else if (start) begin
                elevator_moving = 1'b1;
                remaining       = TRAVEL_CYCLES;
                going_up        = up_request;
            end
        end
    end

endmodule : car_model

`default_nettype wire

/* rtl/floor_request_top.sv */
/*
 * Floor request top level
 * Request lights and destination dispatch for an eleven floor car,
 * joined by the dispatch link
 */

`default_nettype none

module floor_request_top (
    input  wire logic                   clock,
    input  wire logic                   reset_n,

    // Hall and car panel buttons, high while pressed
    input  wire floor_pkg::floor_mask_t floor_call_buttons,
    input  wire floor_pkg::floor_mask_t panel_buttons,
    input  wire logic                   emergency_btn,
    input  wire logic                   power_switch,

    // Car status from the motion controller
    input  wire floor_pkg::floor_t      current_floor,
    input  wire logic                   elevator_moving,

    // Button illumination
    output floor_pkg::floor_mask_t      call_button_lights,
    output floor_pkg::floor_mask_t      panel_button_lights,

    // Commands to the motion controller
    output floor_pkg::floor_t           floor_selector,
    output logic                        direction_selector,
    output logic                        activate_elevator
);

    ////////////////////////////////////////////////////////////////////////////
    // Link between the two blocks
    ////////////////////////////////////////////////////////////////////////////

    dispatch_if link ();

    ////////////////////////////////////////////////////////////////////////////
    // Request lights
    ////////////////////////////////////////////////////////////////////////////

    request_register u_request_register (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .current_floor       (current_floor),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .link                (link.requests)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Target selection and car commands
    ////////////////////////////////////////////////////////////////////////////

    destination_dispatcher u_destination_dispatcher (
        .clock              (clock),
        .reset_n            (reset_n),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .floor_selector     (floor_selector),
        .direction_selector (direction_selector),
        .activate_elevator  (activate_elevator),
        .link               (link.dispatch)
    );

endmodule : floor_request_top

`default_nettype wire

/* rtl/destination_dispatcher.sv */
/*
 * Destination dispatcher
 * Picks the highest pending landing as target, asks the car controller
 * to move towards it and strobes serviced once the car stops there
 */

`default_nettype none

module destination_dispatcher (
    input  wire logic              clock,
    input  wire logic              reset_n,
    input  wire floor_pkg::floor_t current_floor,
    input  wire logic              elevator_moving,
    output floor_pkg::floor_t      floor_selector,
    output logic                   direction_selector,
    output logic                   activate_elevator,
    dispatch_if.dispatch           link
);
    import floor_pkg::*;

    // Highest set bit of the mask, later floors override earlier ones
    function automatic floor_t highest_floor(floor_mask_t mask);
        floor_t floor;
        floor = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (mask[i]) begin
                floor = floor_t'(i);
            end
        end
        return floor;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Decision terms
    ////////////////////////////////////////////////////////////////////////////

    dispatch_state_t state;
    logic            serviced;
    floor_t          serviced_floor;
    floor_t          next_target;
    logic            can_act;
    logic            at_target;
    logic            here_pending;

    // The cycle after a strobe is skipped, the light it cleared
    // still shows in pending at that edge
    assign can_act = link.service_enable && !elevator_moving && !serviced;

    assign at_target    = (current_floor == floor_selector);
    assign here_pending = |(link.pending
                            & (NUM_FLOORS'(1) << current_floor));
    assign next_target  = highest_floor(link.pending);

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state              <= DISP_IDLE;
            floor_selector     <= '0;
            direction_selector <= DIR_UP;
            serviced           <= 1'b0;
        end else begin
            serviced <= 1'b0;
            if (can_act) begin
                case (state)
                    DISP_IDLE: begin
                        if (here_pending) begin
                            // Request at the landing where the car waits
                            serviced <= 1'b1;
                        end else if (link.pending != '0) begin
                            floor_selector     <= next_target;
                            direction_selector <= (next_target > current_floor) ?
                                                  DIR_UP : DIR_DOWN;
                            state              <= DISP_ACTIVE;
                        end
                    end
                    DISP_ACTIVE: begin
                        if (at_target) begin
                            serviced <= 1'b1;
                            state    <= DISP_IDLE;
                        end
                    end
                    default: begin
                        state <= DISP_IDLE;
                    end
                endcase
            end
        end
    end

    // Landing that goes with the strobe
    always_ff @(posedge clock) begin
        if (can_act) begin
            serviced_floor <= (state == DISP_ACTIVE) ? floor_selector : current_floor;
        end
    end

    // Level held until the car stops at the target
    assign activate_elevator = (state == DISP_ACTIVE) && link.service_enable
                               && !elevator_moving && !at_target;

    assign link.serviced       = serviced;
    assign link.serviced_floor = serviced_floor;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_no_activate_moving : assert property (
        @(posedge clock) disable iff (!reset_n)
        elevator_moving |-> !activate_elevator
    ) else $error("activate_elevator high while the car is moving");

    // Strobe lasts one cycle so a light is cleared only once
    a_serviced_single : assert property (
        @(posedge clock) disable iff (!reset_n)
        link.serviced |=> !link.serviced
    ) else $error("serviced strobe held for two cycles");

endmodule : destination_dispatcher

`default_nettype wire

/* rtl/request_register.sv */
/*
 * Request register
 * Latches hall calls and car panel presses into request lights, clears
 * the lights of a serviced floor and publishes the pending mask
 */

`default_nettype none

module request_register (
    input  wire logic                  clock,
    input  wire logic                  reset_n,
    input  wire floor_pkg::floor_mask_t floor_call_buttons,
    input  wire floor_pkg::floor_mask_t panel_buttons,
    input  wire logic                  power_switch,
    input  wire logic                  emergency_btn,
    input  wire floor_pkg::floor_t     current_floor,
    output floor_pkg::floor_mask_t     call_button_lights,
    output floor_pkg::floor_mask_t     panel_button_lights,
    dispatch_if.requests               link
);
    import floor_pkg::*;

    // Landing decoded to one bit, zero for an index past the top floor
    function automatic floor_mask_t floor_onehot(floor_t floor);
        floor_mask_t mask;
        mask = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            mask[i] = (floor == floor_t'(i));
        end
        return mask;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Set and clear masks
    ////////////////////////////////////////////////////////////////////////////

    logic        service_enable;
    floor_mask_t here_mask;
    floor_mask_t clear_mask;
    floor_mask_t call_next;
    floor_mask_t panel_next;

    // Requests are only taken with power on and no emergency
    assign service_enable = power_switch && !emergency_btn;

    // Presses at the landing where the car stands are ignored
    assign here_mask  = floor_onehot(current_floor);
    assign clear_mask = link.serviced ? floor_onehot(link.serviced_floor) : '0;

    // Clearing wins over a press at the same edge
    assign call_next  = (call_button_lights | (floor_call_buttons & ~here_mask))
                        & ~clear_mask;
    assign panel_next = (panel_button_lights | (panel_buttons & ~here_mask))
                        & ~clear_mask;

    ////////////////////////////////////////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (service_enable) begin
            call_button_lights  <= call_next;
            panel_button_lights <= panel_next;
        end
    end

    // Towards the dispatcher
    assign link.pending        = call_button_lights | panel_button_lights;
    assign link.service_enable = service_enable;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // A light that turns on never belongs to the landing the car stood at
    property p_no_light_at_car;
        @(posedge clock) disable iff (!reset_n)
        1'b1 |=> (((call_button_lights & ~$past(call_button_lights))
                  | (panel_button_lights & ~$past(panel_button_lights)))
                  & $past(here_mask)) == '0;
    endproperty

    a_no_light_at_car : assert property (p_no_light_at_car)
        else $error("request light set at the floor where the car stands");

endmodule : request_register

`default_nettype wire

/* rtl/dispatch_if.sv */
/*
 * Request to dispatcher link
 * Pending mask and service enable flow towards the dispatcher, the
 * serviced strobe and its floor flow back to clear the lights
 */

`default_nettype none

interface dispatch_if;
    import floor_pkg::*;

    // Driven by the request register
    floor_mask_t pending;
    logic        service_enable;

    // Driven by the dispatcher, serviced is high for a single cycle
    logic        serviced;
    floor_t      serviced_floor;

    modport requests (
        output pending,
        output service_enable,
        input  serviced,
        input  serviced_floor
    );

    modport dispatch (
        input  pending,
        input  service_enable,
        output serviced,
        output serviced_floor
    );

endinterface : dispatch_if

`default_nettype wire

/* rtl/floor_pkg.sv */
/*
 * Floor request package
 * Landing count, floor and mask types, direction codes and the
 * dispatcher state encoding shared by the request blocks
 */

`default_nettype none

package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Building geometry
    ////////////////////////////////////////////////////////////////////////////

    // Number of landings served by the car
    localparam int NUM_FLOORS = 11;

    // Floor index, 0 is the first landing and 10 the eleventh
    typedef logic [3:0] floor_t;

    // One bit per landing for buttons, lights and pending requests
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////////////////////
    // Car control encodings
    ////////////////////////////////////////////////////////////////////////////

    // Direction selector towards the car controller
    localparam logic DIR_UP   = 1'b1;
    localparam logic DIR_DOWN = 1'b0;

    // Dispatcher FSM states
    typedef enum logic {
        DISP_IDLE   = 1'b0,
        DISP_ACTIVE = 1'b1
    } dispatch_state_t;

endpackage : floor_pkg

`default_nettype wire
